//--- list.f
+incdir+logic
logic/layout_pkg.sv
logic/column_pkg.sv
logic/ifmap_addr_gen.sv
logic/sram_fetch.sv
logic/column_scatter.sv
logic/data_setup.sv
testbench/tb_ifmap_sram.sv
testbench/tb_data_setup.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data setup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f list.f --top-module tb_data_setup -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_data_setup)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

//--- testbench/tb_data_setup.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module tb_data_setup;

	// 3068 words at near four cycles each while four random readies line up
	localparam int timeout_cycles = 20000;

	logic                           clk = 1'b0;
	logic                           rst;
	logic                           start;
	layout_pkg::conv_mode_t         mode;
	logic                           busy;
	logic                           done;
	column_pkg::col_mask_t          fifo_ready = '0;
	column_pkg::col_mask_t          fifo_valid;
	column_pkg::col_byte_t          col_data [`DS_COLS];
	logic                           im_oe;
	logic [`DS_ADDR_W-1:0]          im_a;
	logic [`DS_WORD_W-1:0]          im_do;

	int seed = 4855;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int done_cnt = 0;
	int wr_cnt = 0;
	int run_words;
	int pass_tests = 0;
	int fail_tests = 0;
	layout_pkg::conv_mode_t         ref_mode = layout_pkg::conv_idle;
	column_pkg::col_mask_t          exp_mask;
	logic [`DS_COLS*`DS_BYTE_W-1:0] exp_flat;
	logic [`DS_COLS*`DS_BYTE_W-1:0] col_flat;

	data_setup i_data_setup (.*);
	tb_ifmap_sram i_ifmap_sram (.clk(clk), .oe(im_oe), .addr(im_a), .rdata(im_do));

	always #5 clk = ~clk;

	// expected write number wr_cnt of the running layout
	always_comb begin
		int base;
		int lanes;
		int addr;
		logic [`DS_WORD_W-1:0] w;
		base = 0;
		lanes = 0;
		run_words = 0;
		addr = `DS_PW_BASE + wr_cnt;
		if (ref_mode == layout_pkg::conv_pointwise) begin
			base = (wr_cnt % `DS_PW_C_WORDS) * `DS_PW_LANES;
			lanes = `DS_PW_LANES;
			run_words = `DS_PW_WORDS;
		end else if (ref_mode == layout_pkg::conv_depthwise) begin
			// channel inside row inside stride position
			base = (wr_cnt % `DS_DW_CH) * `DS_DW_LANES;
			lanes = `DS_DW_LANES;
			run_words = `DS_DW_POSITIONS * `DS_DW_ROWS * `DS_DW_CH;
			addr = `DS_DW_BASE + (wr_cnt / (`DS_DW_CH * `DS_DW_ROWS)) * `DS_DW_STRIDE
				+ (wr_cnt / `DS_DW_CH) % `DS_DW_ROWS + (wr_cnt % `DS_DW_CH) * `DS_DW_CH_PITCH;
		end
		w = {2'b10, addr[`DS_ADDR_W-1:0], 2'b01, ~addr[`DS_ADDR_W-1:0]};
		exp_mask = '0;
		exp_flat = '0;
		for (int i = 0; i < lanes; i++) begin
			exp_mask[base + i] = 1'b1;
			exp_flat[(base + i) * `DS_BYTE_W +: `DS_BYTE_W] = w[i * `DS_BYTE_W +: `DS_BYTE_W];
		end
		for (int i = 0; i < `DS_COLS; i++) begin
			col_flat[i * `DS_BYTE_W +: `DS_BYTE_W] = col_data[i];
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
		// count restarts only on an accepted start
		if (start && !busy && mode != layout_pkg::conv_idle) begin
			wr_cnt <= 0;
		end else if (fifo_valid != '0) begin
			wr_cnt <= wr_cnt + 1;
		end
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: the runs did not end within %0d cycles", timeout_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// each column ready about seven cycles in ten
	always @(negedge clk) begin
		for (int i = 0; i < `DS_COLS; i++) begin
			fifo_ready[i] = ({$random(seed)} % 10) < 7;
		end
	end

	a_reset: assert property (@(posedge clk) rst |-> !busy && !done && !im_oe && fifo_valid == '0)
		else record_error($sformatf("error: in reset busy %h done %h im_oe %h fifo_valid %h",
			$sampled(busy), $sampled(done), $sampled(im_oe), $sampled(fifo_valid)));
	a_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !im_oe && fifo_valid == '0)
		else record_error($sformatf("error: while idle im_oe %h fifo_valid %h",
			$sampled(im_oe), $sampled(fifo_valid)));
	a_idle_start: assert property (@(posedge clk) disable iff (rst)
		start && !busy && mode == layout_pkg::conv_idle |=> !busy)
		else record_error($sformatf("error: busy %h after a start with mode idle",
			$sampled(busy)));
	a_ready: assert property (@(posedge clk) disable iff (rst) (fifo_valid & ~fifo_ready) == '0)
		else record_error($sformatf("error: fifo_valid %h with fifo_ready %h",
			$sampled(fifo_valid), $sampled(fifo_ready)));
	a_col15: assert property (@(posedge clk) disable iff (rst) !fifo_valid[`DS_COLS-1])
		else record_error($sformatf("error: fifo_valid %h sets column 15", $sampled(fifo_valid)));
	a_write: assert property (@(posedge clk) disable iff (rst)
		fifo_valid != '0 |-> fifo_valid == exp_mask && col_flat == exp_flat)
		else record_error($sformatf("error: fifo_valid %h col_data %h expected %h %h",
			$sampled(fifo_valid), $sampled(col_flat), $sampled(exp_mask), $sampled(exp_flat)));
	a_done: assert property (@(posedge clk) disable iff (rst)
		done == (fifo_valid != '0 && wr_cnt == run_words - 1))
		else record_error($sformatf("error: done %h at write %h of %h",
			$sampled(done), $sampled(wr_cnt), $sampled(run_words)));
	a_busy_fall: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
		else record_error($sformatf("error: busy %h on the edge after done", $sampled(busy)));

	task automatic record_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_tests++;
			$display("test %s: ok", name);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic run_layer(input string name, input layout_pkg::conv_mode_t m, input bit poke);
		int errs_before;
		int seen;
		errs_before = err_cnt;
		seen = done_cnt;
		ref_mode = m;
		mode = m;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (poke) begin
			// second start in the middle of the run
			repeat (40) @(negedge clk);
			mode = layout_pkg::conv_pointwise;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		mode = layout_pkg::conv_idle;
		while (done_cnt == seen) begin
			@(negedge clk);
		end
		@(negedge clk);
		ref_mode = layout_pkg::conv_idle;
		report_test(name, errs_before);
	endtask

	initial begin
		int errs_before;
		rst = 1'b1;
		start = 1'b0;
		mode = layout_pkg::conv_idle;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);
		report_test("reset", 0);
		run_layer("pointwise", layout_pkg::conv_pointwise, 1'b0);
		run_layer("depthwise", layout_pkg::conv_depthwise, 1'b1);
		// idle mode start leaves the pipeline quiet
		errs_before = err_cnt;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (20) @(negedge clk);
		report_test("idle start", errs_before);
		$display("tests passed %0d, failed %0d", pass_tests, fail_tests);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/tb_ifmap_sram.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module tb_ifmap_sram (
	input  logic                  clk,
	input  logic                  oe,
	input  logic [`DS_ADDR_W-1:0] addr,
	output logic [`DS_WORD_W-1:0] rdata
);

	// word appears on the edge after oe
	// upper half carries the address, lower half its complement
	always_ff @(posedge clk) begin
		if (oe) begin
			rdata <= {2'b10, addr, 2'b01, ~addr};
		end
	end

endmodule

//--- logic/data_setup.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module data_setup (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  layout_pkg::conv_mode_t  mode,
	output logic                    busy,
	output logic                    done,
	input  column_pkg::col_mask_t   fifo_ready,
	output column_pkg::col_mask_t   fifo_valid,
	output column_pkg::col_byte_t   col_data [`DS_COLS],
	output logic                    im_oe,
	output logic [`DS_ADDR_W-1:0]   im_a,
	input  logic [`DS_WORD_W-1:0]   im_do
);

	// address generation to fetch
	logic                   req_valid;
	logic                   req_ready;
	logic [`DS_ADDR_W-1:0]  req_addr;
	column_pkg::col_group_t req_group;
	logic                   req_last;
	layout_pkg::conv_mode_t req_mode;

	// fetch to scatter
	logic                   word_valid;
	logic                   word_ready;
	layout_pkg::sram_word_t word;
	column_pkg::col_group_t word_group;
	logic                   word_last;
	layout_pkg::conv_mode_t word_mode;

	ifmap_addr_gen i_ifmap_addr_gen (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.mode      (mode),
		.run_done  (done),
		.busy      (busy),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_addr  (req_addr),
		.req_group (req_group),
		.req_last  (req_last),
		.req_mode  (req_mode)
	);

	sram_fetch i_sram_fetch (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_addr   (req_addr),
		.req_group  (req_group),
		.req_last   (req_last),
		.req_mode   (req_mode),
		.im_oe      (im_oe),
		.im_a       (im_a),
		.im_do      (im_do),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.word       (word),
		.word_group (word_group),
		.word_last  (word_last),
		.word_mode  (word_mode)
	);

	// done is the last column write of the run
	column_scatter i_column_scatter (
		.word_valid (word_valid),
		.word_ready (word_ready),
		.word       (word),
		.word_group (word_group),
		.word_last  (word_last),
		.word_mode  (word_mode),
		.fifo_ready (fifo_ready),
		.fifo_valid (fifo_valid),
		.col_data   (col_data),
		.run_done   (done)
	);

endmodule

//--- logic/column_scatter.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module column_scatter (
	input  logic                    word_valid,
	output logic                    word_ready,
	input  layout_pkg::sram_word_t  word,
	input  column_pkg::col_group_t  word_group,
	input  logic                    word_last,
	input  layout_pkg::conv_mode_t  word_mode,
	input  column_pkg::col_mask_t   fifo_ready,
	output column_pkg::col_mask_t   fifo_valid,
	output column_pkg::col_byte_t   col_data [`DS_COLS],
	output logic                    run_done
);

	localparam int CW = $clog2(`DS_COLS) + 1;

	logic [CW-1:0]         col_base;
	logic [CW-1:0]         lane_cnt;
	column_pkg::col_mask_t target;
	logic                  grp_ready;
	logic                  fire;

	// first column and width of the group
	always_comb begin
		case (word_mode)
			layout_pkg::conv_pointwise: begin
				col_base = CW'(word_group) * CW'(`DS_PW_LANES);
				lane_cnt = CW'(`DS_PW_LANES);
			end
			layout_pkg::conv_depthwise: begin
				col_base = CW'(word_group) * CW'(`DS_DW_LANES);
				lane_cnt = CW'(`DS_DW_LANES);
			end
			default: begin
				col_base = '0;
				lane_cnt = '0;
			end
		endcase
	end

	always_comb begin
		logic [CW-1:0] off;
		for (int i = 0; i < `DS_COLS; i++) begin
			off       = CW'(i) - col_base;
			target[i] = (CW'(i) >= col_base) && (off < lane_cnt);
		end
	end

	// every column of the group must take its byte in the same cycle
	assign grp_ready = &(fifo_ready | ~target);
	assign fire      = word_valid && (target != '0) && grp_ready;

	assign word_ready = fire;
	assign run_done   = fire && word_last;
	assign fifo_valid = fire ? target : '0;

	always_comb begin
		logic [CW-1:0] off;
		for (int i = 0; i < `DS_COLS; i++) begin
			off = CW'(i) - col_base;
			if (fire && target[i]) begin
				if (word_mode == layout_pkg::conv_pointwise) begin
					col_data[i] = word.pw.lane[off[1:0]];
				end else begin
					// depthwise uses only the low three bytes
					col_data[i] = word.dw.lane[off[1:0]];
				end
			end else begin
				col_data[i] = '0;
			end
		end
	end

endmodule

//--- logic/sram_fetch.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module sram_fetch (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	output logic                    req_ready,
	input  logic [`DS_ADDR_W-1:0]   req_addr,
	input  column_pkg::col_group_t  req_group,
	input  logic                    req_last,
	input  layout_pkg::conv_mode_t  req_mode,
	output logic                    im_oe,
	output logic [`DS_ADDR_W-1:0]   im_a,
	input  logic [`DS_WORD_W-1:0]   im_do,
	output logic                    word_valid,
	input  logic                    word_ready,
	output layout_pkg::sram_word_t  word,
	output column_pkg::col_group_t  word_group,
	output logic                    word_last,
	output layout_pkg::conv_mode_t  word_mode
);

	localparam int DEPTH = 2;
	localparam int PTR_W = $clog2(DEPTH);

	// tag of the read in flight
	logic                   rd_pend;
	column_pkg::col_group_t rd_group;
	logic                   rd_last;
	layout_pkg::conv_mode_t rd_mode;

	// two-entry queue
	layout_pkg::sram_word_t q_word  [DEPTH];
	column_pkg::col_group_t q_group [DEPTH];
	logic                   q_last  [DEPTH];
	layout_pkg::conv_mode_t q_mode  [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [1:0]       q_cnt;

	logic push;
	logic pop;

	// queued words plus the pending read may not exceed the depth
	assign req_ready = (q_cnt + {1'b0, rd_pend}) < 2'(DEPTH);

	assign im_oe = req_valid && req_ready;
	assign im_a  = im_oe ? req_addr : '0;

	// im_do carries the word one edge after the read
	assign push = rd_pend;
	assign pop  = word_valid && word_ready;

	assign word_valid = q_cnt != 2'd0;
	assign word       = q_word[rd_ptr];
	assign word_group = q_group[rd_ptr];
	assign word_last  = q_last[rd_ptr];
	assign word_mode  = q_mode[rd_ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= im_oe;
		end
	end

	always_ff @(posedge clk) begin
		if (im_oe) begin
			rd_group <= req_group;
			rd_last  <= req_last;
			rd_mode  <= req_mode;
		end
		if (push) begin
			q_word[wr_ptr]  <= im_do;
			q_group[wr_ptr] <= rd_group;
			q_last[wr_ptr]  <= rd_last;
			q_mode[wr_ptr]  <= rd_mode;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
		end
	end

endmodule

//--- logic/ifmap_addr_gen.sv
`timescale 1ns/10ps
`include "data_setup_config.svh"

module ifmap_addr_gen (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  layout_pkg::conv_mode_t  mode,
	input  logic                    run_done,
	output logic                    busy,
	output logic                    req_valid,
	input  logic                    req_ready,
	output logic [`DS_ADDR_W-1:0]   req_addr,
	output column_pkg::col_group_t  req_group,
	output logic                    req_last,
	output layout_pkg::conv_mode_t  req_mode
);

	localparam int AW      = `DS_ADDR_W;
	localparam int PW_CNT_W = $clog2(`DS_PW_WORDS);
	localparam int CW_W    = $clog2(`DS_PW_C_WORDS);
	localparam int CH_W    = $clog2(`DS_DW_CH);
	localparam int ROW_W   = $clog2(`DS_DW_ROWS);
	localparam int POS_W   = $clog2(`DS_DW_POSITIONS);

	layout_pkg::conv_mode_t run_mode;

	// pointwise counters
	logic [PW_CNT_W-1:0] pw_cnt;
	logic [CW_W-1:0]     cw_cnt;

	// depthwise counters, channel innermost
	logic [CH_W-1:0]  ch_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic [POS_W-1:0] pos_cnt;

	logic start_ok;
	logic xfer;
	logic pw_last;
	logic dw_last;
	logic ch_wrap;
	logic row_wrap;
	logic [AW-1:0] pw_addr;
	logic [AW-1:0] dw_addr;

	assign start_ok = start && !busy &&
		(mode == layout_pkg::conv_pointwise || mode == layout_pkg::conv_depthwise);
	assign xfer = req_valid && req_ready;

	assign ch_wrap  = ch_cnt == CH_W'(`DS_DW_CH - 1);
	assign row_wrap = row_cnt == ROW_W'(`DS_DW_ROWS - 1);
	assign pw_last  = pw_cnt == PW_CNT_W'(`DS_PW_WORDS - 1);
	assign dw_last  = ch_wrap && row_wrap && (pos_cnt == POS_W'(`DS_DW_POSITIONS - 1));

	// linear walk for NHWC
	assign pw_addr = AW'(`DS_PW_BASE) + AW'(pw_cnt);

	// channel plane, then stride position, then kernel row
	assign dw_addr = AW'(`DS_DW_BASE)
		+ AW'(pos_cnt) * AW'(`DS_DW_STRIDE)
		+ AW'(row_cnt)
		+ AW'(ch_cnt) * AW'(`DS_DW_CH_PITCH);

	assign req_mode = run_mode;

	always_comb begin
		if (run_mode == layout_pkg::conv_pointwise) begin
			req_addr  = pw_addr;
			req_group = column_pkg::col_group_t'(cw_cnt);
			req_last  = pw_last;
		end else begin
			req_addr  = dw_addr;
			req_group = column_pkg::col_group_t'(ch_cnt);
			req_last  = dw_last;
		end
	end

	// run state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy      <= 1'b0;
			req_valid <= 1'b0;
			run_mode  <= layout_pkg::conv_idle;
		end else if (start_ok) begin
			busy      <= 1'b1;
			req_valid <= 1'b1;
			run_mode  <= mode;
		end else begin
			if (xfer && req_last) begin
				req_valid <= 1'b0;
			end
			// last column write seen by scatter
			if (run_done) begin
				busy <= 1'b0;
			end
		end
	end

	// loop counters move only on a request transfer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pw_cnt  <= '0;
			cw_cnt  <= '0;
			ch_cnt  <= '0;
			row_cnt <= '0;
			pos_cnt <= '0;
		end else if (start_ok) begin
			pw_cnt  <= '0;
			cw_cnt  <= '0;
			ch_cnt  <= '0;
			row_cnt <= '0;
			pos_cnt <= '0;
		end else if (xfer) begin
			if (run_mode == layout_pkg::conv_pointwise) begin
				pw_cnt <= pw_cnt + 1'b1;
				if (cw_cnt == CW_W'(`DS_PW_C_WORDS - 1)) begin
					cw_cnt <= '0;
				end else begin
					cw_cnt <= cw_cnt + 1'b1;
				end
			end else begin
				if (ch_wrap) begin
					ch_cnt <= '0;
					if (row_wrap) begin
						row_cnt <= '0;
						pos_cnt <= pos_cnt + 1'b1;
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end else begin
					ch_cnt <= ch_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/column_pkg.sv
`include "data_setup_config.svh"

package column_pkg;

	// pointwise channel word 0..1 or depthwise channel 0..4
	typedef logic [2:0] col_group_t;

	// one bit per column fifo
	typedef logic [`DS_COLS-1:0] col_mask_t;

	// data byte toward one column
	typedef logic [`DS_BYTE_W-1:0] col_byte_t;

endpackage

//--- logic/layout_pkg.sv
`include "data_setup_config.svh"

package layout_pkg;

	// coded as the mode input of the accelerator
	typedef enum logic [1:0] {
		conv_idle      = 2'd0,
		conv_depthwise = 2'd1,
		conv_pointwise = 2'd2
	} conv_mode_t;

	// pointwise word, four channel bytes, lane 0 in the low byte
	typedef struct packed {
		logic [`DS_PW_LANES-1:0][`DS_BYTE_W-1:0] lane;
	} pw_view_t;

	// depthwise word, three pixels of one row, top byte unused
	typedef struct packed {
		logic [`DS_WORD_W-`DS_DW_LANES*`DS_BYTE_W-1:0] pad;
		logic [`DS_DW_LANES-1:0][`DS_BYTE_W-1:0]        lane;
	} dw_view_t;

	// one sram word, read through the view of the running mode
	typedef union packed {
		pw_view_t pw;
		dw_view_t dw;
	} sram_word_t;

endpackage

//--- logic/data_setup_config.svh
`ifndef DATA_SETUP_CONFIG_SVH
`define DATA_SETUP_CONFIG_SVH

// column side
`define DS_COLS 16
`define DS_BYTE_W 8

// input sram
`define DS_WORD_W 32
`define DS_ADDR_W 14

// pointwise feature map, NHWC with two channel words per pixel
`define DS_PW_H 28
`define DS_PW_W 28
`define DS_PW_C_WORDS 2
`define DS_PW_BASE 0
`define DS_PW_WORDS (`DS_PW_H * `DS_PW_W * `DS_PW_C_WORDS)

// depthwise feature map, NCHW, one block of five channels
`define DS_DW_CH 5
`define DS_DW_ROWS 3
`define DS_DW_STRIDE 3
`define DS_DW_POSITIONS 100
`define DS_DW_CH_PITCH (`DS_DW_POSITIONS * `DS_DW_STRIDE)
`define DS_DW_BASE 0

// bytes taken from each word
`define DS_DW_LANES 3
`define DS_PW_LANES 4

`endif
